// ==== verilog/axil_link_params.svh ====
/*
 * link bridge parameters
 * slot count, receive FIFO depth, AXI-Lite address map and ROM contents
 */

`ifndef AXIL_LINK_PARAMS_SVH
`define AXIL_LINK_PARAMS_SVH

// receive slots and per-slot FIFO entries (depth is a power of two)
`define AXIL_NUM_SLOTS 2
`define AXIL_FIFO_DEPTH 4
`define AXIL_FIFO_CNT_WIDTH $clog2(`AXIL_FIFO_DEPTH + 1)

// address split into slot index and in-slot byte offset
`define AXIL_OFS_WIDTH 12
`define AXIL_SLOT_IDX_WIDTH 4
`define AXIL_FIRST_SLOT_IDX 1

// slot register byte offsets
`define AXIL_OFS_RDFO 12'h01C
`define AXIL_OFS_RDR 12'h020
`define AXIL_OFS_RLR 12'h024

// information ROM
`define AXIL_ROM_WORDS 4
`define AXIL_ROM_MAGIC 32'h4C4E_4B31
`define AXIL_ROM_VERSION 32'h0000_0100

`endif

// ==== verilog/axil_bus_pkg.sv ====
/*
 * AXI-Lite bus types
 * read response code and the two views of a read address word
 */

`include "axil_link_params.svh"

package axil_bus_pkg;

  // ----------------------------------------------------------------------
  // read response
  // ----------------------------------------------------------------------

  // only OKAY and DECERR are ever returned
  typedef enum logic [1:0] {
    AXIL_RESP_OKAY   = 2'b00,
    AXIL_RESP_DECERR = 2'b11
  } axil_resp_e;

  // ----------------------------------------------------------------------
  // read address word
  // ----------------------------------------------------------------------

  // raw view for word indexing, field view for slot/offset decode
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [31-`AXIL_SLOT_IDX_WIDTH-`AXIL_OFS_WIDTH:0] spare;
      logic [`AXIL_SLOT_IDX_WIDTH-1:0] slot_idx;
      logic [`AXIL_OFS_WIDTH-1:0] ofs;
    } f;
  } axil_rd_addr_u;

endpackage

// ==== verilog/link_stream_pkg.sv ====
/*
 * link stream types
 * stream word and the register offsets inside a receive slot
 */

`include "axil_link_params.svh"

package link_stream_pkg;

  // one word as pushed by the link side
  typedef logic [31:0] link_word_t;

  // ----------------------------------------------------------------------
  // slot registers
  // ----------------------------------------------------------------------

  // RDFO occupancy, RDR data (pops the FIFO), RLR received-word count
  typedef enum logic [`AXIL_OFS_WIDTH-1:0] {
    SLOT_REG_RDFO = `AXIL_OFS_RDFO,
    SLOT_REG_RDR  = `AXIL_OFS_RDR,
    SLOT_REG_RLR  = `AXIL_OFS_RLR
  } slot_reg_e;

endpackage

// ==== verilog/rx_stream_fifo.sv ====
/*
 * receive FIFO for one slot
 * circular buffer with occupancy count, head word reads zero when empty
 */

`timescale 1ns/1ns

`include "axil_link_params.svh"

module rx_stream_fifo (
  input                                    clk_i
  , input                                  reset_i
  // link side push
  , input                                  push_v_i
  , input  link_stream_pkg::link_word_t    push_data_i
  , output                                 push_ready_o
  // reader side
  , input                                  pop_i
  , output link_stream_pkg::link_word_t    head_o
  , output [`AXIL_FIFO_CNT_WIDTH-1:0]      count_o
);

  localparam int depth_lp     = `AXIL_FIFO_DEPTH;
  localparam int ptr_width_lp = $clog2(depth_lp);
  localparam int cnt_width_lp = `AXIL_FIFO_CNT_WIDTH;

  // payload storage
  link_stream_pkg::link_word_t mem_r [depth_lp];

  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;

  logic full;
  logic empty;
  logic push_fire;
  logic pop_fire;

  assign full  = (count_r == cnt_width_lp'(depth_lp));
  assign empty = (count_r == '0);

  // pop on empty is dropped here
  assign push_fire = push_v_i & ~full;
  assign pop_fire  = pop_i & ~empty;

  // ----------------------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      // pointers wrap on their own since depth is a power of two
      if (push_fire) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      // push and pop together leave the count alone
      if (push_fire & ~pop_fire) begin
        count_r <= count_r + 1'b1;
      end else if (pop_fire & ~push_fire) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_r[wr_ptr_r] <= push_data_i;
    end
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------

  assign push_ready_o = ~full;
  // zero head keeps a read of an empty slot clean
  assign head_o       = empty ? '0 : mem_r[rd_ptr_r];
  assign count_o      = count_r;

endmodule

// ==== verilog/rx_slot_status.sv ====
/*
 * status registers for one receive slot
 * received-word counter and occupancy, picked by the in-slot offset
 */

`timescale 1ns/1ns

`include "axil_link_params.svh"

module rx_slot_status (
  input                                clk_i
  , input                              reset_i
  // accepted push on this slot
  , input                              push_fire_i
  // FIFO occupancy
  , input  [`AXIL_FIFO_CNT_WIDTH-1:0]  count_i
  // latched read address from the reader
  , input  [31:0]                      rd_addr_i
  , output logic [31:0]                status_o
);

  axil_bus_pkg::axil_rd_addr_u rd_addr;
  link_stream_pkg::slot_reg_e  reg_sel;

  logic [31:0] rx_count_r;

  // ----------------------------------------------------------------------
  // received-word counter
  // ----------------------------------------------------------------------

  // free-running counter that wraps at 32 bits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_count_r <= '0;
    end else if (push_fire_i) begin
      rx_count_r <= rx_count_r + 32'd1;
    end
  end

  // ----------------------------------------------------------------------
  // register select
  // ----------------------------------------------------------------------

  // only the offset field matters here
  assign rd_addr = rd_addr_i;
  assign reg_sel = link_stream_pkg::slot_reg_e'(rd_addr.f.ofs);

  always_comb begin
    case (reg_sel)
      // zero-extended occupancy
      link_stream_pkg::SLOT_REG_RDFO: status_o = 32'(count_i);
      link_stream_pkg::SLOT_REG_RLR:  status_o = rx_count_r;
      // RDR comes from the FIFO head in the reader
      default:                        status_o = '0;
    endcase
  end

endmodule

// ==== verilog/link_info_rom.sv ====
/*
 * link information ROM
 * magic, slot count, FIFO depth and version by word offset
 */

`timescale 1ns/1ns

`include "axil_link_params.svh"

module link_info_rom (
  input  [31:0]  rd_addr_i
  , output [31:0] rom_o
);

  localparam int word_idx_w_lp = `AXIL_OFS_WIDTH - 2;
  localparam int rom_idx_w_lp  = $clog2(`AXIL_ROM_WORDS);

  // word contents in word order
  localparam logic [31:0] rom_lp [`AXIL_ROM_WORDS] = '{
    `AXIL_ROM_MAGIC,
    32'(`AXIL_NUM_SLOTS),
    32'(`AXIL_FIFO_DEPTH),
    `AXIL_ROM_VERSION
  };

  logic [31:0]              word_addr;
  logic [word_idx_w_lp-1:0] word_idx;
  logic [rom_idx_w_lp-1:0]  rom_idx;
  logic                     in_range;

  // byte address to word address
  assign word_addr = rd_addr_i >> 2;
  // keep only the words inside one slot
  assign word_idx  = word_addr[word_idx_w_lp-1:0];
  assign rom_idx   = word_idx[rom_idx_w_lp-1:0];
  assign in_range  = (word_idx < word_idx_w_lp'(`AXIL_ROM_WORDS));

  // words past the table read zero
  assign rom_o = in_range ? rom_lp[rom_idx] : '0;

endmodule

// ==== verilog/axil_rx_reader.sv ====
/*
 * AXI-Lite read slave for the receive slots
 * idle/address/data FSM, slot decode, data select, DECERR and FIFO pop
 */

`timescale 1ns/1ns

`include "axil_link_params.svh"

module axil_rx_reader (
  input                                                         clk_i
  , input                                                       reset_i
  // AXI-Lite read address and data channels
  , input  [31:0]                                               araddr_i
  , input                                                       arvalid_i
  , output                                                      arready_o
  , output logic [31:0]                                         rdata_o
  , output axil_bus_pkg::axil_resp_e                            rresp_o
  , output                                                      rvalid_o
  , input                                                       rready_i
  // FIFO heads, status words and ROM word
  , input  link_stream_pkg::link_word_t [`AXIL_NUM_SLOTS-1:0]   fifo_data_i
  , input  [`AXIL_NUM_SLOTS-1:0][31:0]                          status_data_i
  , input  [31:0]                                               rom_data_i
  // pop pulse and latched address
  , output [`AXIL_NUM_SLOTS-1:0]                                fifo_pop_o
  , output [31:0]                                               rd_addr_o
);

  localparam int num_slots_lp  = `AXIL_NUM_SLOTS;
  localparam int slot_idx_w_lp = `AXIL_SLOT_IDX_WIDTH;
  localparam int slot_sel_w_lp = (num_slots_lp > 1) ? $clog2(num_slots_lp) : 1;

  // FSM encoding
  localparam logic [1:0] st_idle_lp = 2'd0;
  localparam logic [1:0] st_addr_lp = 2'd1;
  localparam logic [1:0] st_data_lp = 2'd2;

  logic [1:0] state_r;
  logic [1:0] state_n;
  logic       in_idle;
  logic       in_data;
  logic       ar_fire;
  logic       r_fire;

  axil_bus_pkg::axil_rd_addr_u addr_r;

  logic [num_slots_lp-1:0]  slot_hit;
  logic                     rom_hit;
  logic                     any_hit;
  logic                     data_reg;
  logic [slot_sel_w_lp-1:0] slot_sel;

  // ----------------------------------------------------------------------
  // read FSM
  // ----------------------------------------------------------------------

  assign in_idle = (state_r == st_idle_lp);
  assign in_data = (state_r == st_data_lp);

  assign ar_fire = arvalid_i & arready_o;
  assign r_fire  = rvalid_o & rready_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      // ready for an address only here
      st_idle_lp: begin
        if (ar_fire) begin
          state_n = st_addr_lp;
        end
      end
      // address is in the flop while decode settles
      st_addr_lp: begin
        state_n = st_data_lp;
      end
      // hold the response until the host takes it
      st_data_lp: begin
        if (r_fire) begin
          state_n = st_idle_lp;
        end
      end
      default: state_n = st_idle_lp;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle_lp;
    end else begin
      state_r <= state_n;
    end
  end

  // address flop loaded on the handshake only
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      addr_r <= araddr_i;
    end
  end

  // ----------------------------------------------------------------------
  // slot and offset decode
  // ----------------------------------------------------------------------

  // receive slot i sits at index i plus the first slot index
  for (genvar i = 0; i < num_slots_lp; i++) begin : g_hit
    assign slot_hit[i] = in_data
      && (addr_r.f.slot_idx == slot_idx_w_lp'(i + `AXIL_FIRST_SLOT_IDX));
  end

  // ROM follows the last receive slot
  assign rom_hit = in_data
    && (addr_r.f.slot_idx == slot_idx_w_lp'(num_slots_lp + `AXIL_FIRST_SLOT_IDX));

  assign any_hit  = (|slot_hit) | rom_hit;
  assign data_reg = (addr_r.f.ofs == link_stream_pkg::SLOT_REG_RDR);

  // one-hot hit vector to slot number
  always_comb begin
    slot_sel = '0;
    for (int i = 0; i < num_slots_lp; i++) begin
      if (slot_hit[i]) begin
        slot_sel = slot_sel_w_lp'(i);
      end
    end
  end

  // ----------------------------------------------------------------------
  // read data and response
  // ----------------------------------------------------------------------

  always_comb begin
    if (rom_hit) begin
      rdata_o = rom_data_i;
    end else if (|slot_hit) begin
      // data register gives the FIFO head, anything else the status word
      rdata_o = data_reg ? fifo_data_i[slot_sel] : status_data_i[slot_sel];
    end else begin
      rdata_o = '0;
    end
  end

  // unmapped slot index while a response is up
  assign rresp_o = (in_data & ~any_hit) ? axil_bus_pkg::AXIL_RESP_DECERR
                                        : axil_bus_pkg::AXIL_RESP_OKAY;

  assign arready_o = in_idle;
  assign rvalid_o  = in_data;

  // pop the addressed FIFO as the data-register response completes
  assign fifo_pop_o = {num_slots_lp{r_fire & data_reg}} & slot_hit;

  assign rd_addr_o = addr_r.raw;

endmodule

// ==== verilog/axil_rx_subsystem.sv ====
/*
 * receive side of the AXI-Lite link bridge
 * per-slot FIFO and status, information ROM and the read slave
 */

`timescale 1ns/1ns

`include "axil_link_params.svh"

module axil_rx_subsystem (
  input                                                         clk_i
  , input                                                       reset_i
  // AXI-Lite read channels
  , input  [31:0]                                               araddr_i
  , input                                                       arvalid_i
  , output                                                      arready_o
  , output [31:0]                                               rdata_o
  , output axil_bus_pkg::axil_resp_e                            rresp_o
  , output                                                      rvalid_o
  , input                                                       rready_i
  // link side pushes with one lane per slot
  , input  [`AXIL_NUM_SLOTS-1:0]                                rx_v_i
  , input  link_stream_pkg::link_word_t [`AXIL_NUM_SLOTS-1:0]   rx_data_i
  , output [`AXIL_NUM_SLOTS-1:0]                                rx_ready_o
);

  localparam int num_slots_lp = `AXIL_NUM_SLOTS;

  logic [num_slots_lp-1:0]                            push_fire;
  logic [num_slots_lp-1:0]                            rd_pop;
  link_stream_pkg::link_word_t [num_slots_lp-1:0]     fifo_head;
  logic [num_slots_lp-1:0][`AXIL_FIFO_CNT_WIDTH-1:0]  fifo_count;
  logic [num_slots_lp-1:0][31:0]                      status_word;
  logic [31:0]                                        rd_addr;
  logic [31:0]                                        rom_word;

  // ----------------------------------------------------------------------
  // receive slots
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < num_slots_lp; i++) begin : g_slot
    // counted only when the FIFO takes the word
    assign push_fire[i] = rx_v_i[i] & rx_ready_o[i];

    rx_stream_fifo u_fifo (
      .clk_i        (clk_i)
      , .reset_i    (reset_i)
      , .push_v_i   (rx_v_i[i])
      , .push_data_i(rx_data_i[i])
      , .push_ready_o(rx_ready_o[i])
      , .pop_i      (rd_pop[i])
      , .head_o     (fifo_head[i])
      , .count_o    (fifo_count[i])
    );

    rx_slot_status u_status (
      .clk_i        (clk_i)
      , .reset_i    (reset_i)
      , .push_fire_i(push_fire[i])
      , .count_i    (fifo_count[i])
      , .rd_addr_i  (rd_addr)
      , .status_o   (status_word[i])
    );
  end

  // ----------------------------------------------------------------------
  // ROM and read slave
  // ----------------------------------------------------------------------

  link_info_rom u_rom (
    .rd_addr_i(rd_addr)
    , .rom_o  (rom_word)
  );

  axil_rx_reader u_reader (
    .clk_i          (clk_i)
    , .reset_i      (reset_i)
    , .araddr_i     (araddr_i)
    , .arvalid_i    (arvalid_i)
    , .arready_o    (arready_o)
    , .rdata_o      (rdata_o)
    , .rresp_o      (rresp_o)
    , .rvalid_o     (rvalid_o)
    , .rready_i     (rready_i)
    , .fifo_data_i  (fifo_head)
    , .status_data_i(status_word)
    , .rom_data_i   (rom_word)
    , .fifo_pop_o   (rd_pop)
    , .rd_addr_o    (rd_addr)
  );

endmodule

// ==== testbench/tb_axil_rx.sv ====
/*
 * directed testbench for the AXI-Lite receive subsystem
 * pushes link words, reads ROM, data and status registers, checks responses
 */

`timescale 1ns/1ns

`include "axil_link_params.svh"

module tb_axil_rx;

  localparam int num_slots_lp = `AXIL_NUM_SLOTS;
  localparam int depth_lp     = `AXIL_FIFO_DEPTH;
  localparam int max_wait_lp  = 50;
  // ROM sits right after the last receive slot
  localparam int rom_idx_lp   = `AXIL_NUM_SLOTS + `AXIL_FIRST_SLOT_IDX;

  logic                                           clk;
  logic                                           reset;
  logic [31:0]                                    araddr;
  logic                                           arvalid;
  logic                                           arready;
  logic [31:0]                                    rdata;
  axil_bus_pkg::axil_resp_e                       rresp;
  logic                                           rvalid;
  logic                                           rready;
  logic [num_slots_lp-1:0]                        rx_v;
  link_stream_pkg::link_word_t [num_slots_lp-1:0] rx_data;
  logic [num_slots_lp-1:0]                        rx_ready;

  // reference model with words in push order and running totals per slot
  logic [31:0] model_q [num_slots_lp][$];
  int          rx_total [num_slots_lp];
  integer      seed;
  string       test_name;

  axil_rx_subsystem u_axil_rx_subsystem (
    .clk_i      (clk)
    , .reset_i  (reset)
    , .araddr_i (araddr)
    , .arvalid_i(arvalid)
    , .arready_o(arready)
    , .rdata_o  (rdata)
    , .rresp_o  (rresp)
    , .rvalid_o (rvalid)
    , .rready_i (rready)
    , .rx_v_i   (rx_v)
    , .rx_data_i(rx_data)
    , .rx_ready_o(rx_ready)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  // inputs change and outputs are sampled 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input string label, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch in %s (%s): expected %h, actual %h",
               test_name, label, expected, actual);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in %s: %s not seen within %0d cycles", test_name, what, max_wait_lp);
    $display("Verification failed");
    $fatal(1, "wait limit reached");
  endtask

  // slot index in bits 15:12, byte offset in bits 11:0
  function automatic logic [31:0] reg_addr(input int idx, input logic [11:0] ofs);
    reg_addr = (idx << `AXIL_OFS_WIDTH) | {20'h0, ofs};
  endfunction

  task automatic push_word(input int slot, input logic [31:0] data);
    int waited;
    waited = 0;
    rx_v[slot]    = 1'b1;
    rx_data[slot] = data;
    while (!rx_ready[slot]) begin
      next_cycle();
      waited++;
      if (waited >= max_wait_lp) report_timeout("rx_ready");
    end
    // push happens on this edge
    next_cycle();
    rx_v[slot] = 1'b0;
    model_q[slot].push_back(data);
    rx_total[slot]++;
  endtask

  task automatic axil_read(input logic [31:0] addr, input int rready_delay,
                           output logic [31:0] data, output logic [1:0] resp);
    int waited;
    waited  = 0;
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
      next_cycle();
      waited++;
      if (waited >= max_wait_lp) report_timeout("arready_o");
    end
    // address handshake edge
    next_cycle();
    arvalid = 1'b0;
    waited  = 0;
    while (!rvalid) begin
      next_cycle();
      waited++;
      if (waited >= max_wait_lp) report_timeout("rvalid_o");
    end
    // rvalid two edges after the handshake edge
    check("rvalid latency", 32'd2, 32'(waited + 1));
    data = rdata;
    resp = rresp;
    // response must hold under back-pressure
    for (int i = 0; i < rready_delay; i++) begin
      next_cycle();
      check("rvalid held", 32'd1, 32'(rvalid));
      check("rdata held", data, rdata);
      check("rresp held", 32'(resp), 32'(rresp));
      check("arready while pending", 32'd0, 32'(arready));
    end
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
    check("arready after response", 32'd1, 32'(arready));
  endtask

  // data register read compared with the head of the model queue
  task automatic pop_and_compare(input int slot, input int rready_delay);
    logic [31:0] data;
    logic [1:0]  resp;
    logic [31:0] expected;
    expected = 32'h0;
    axil_read(reg_addr(slot + `AXIL_FIRST_SLOT_IDX, `AXIL_OFS_RDR), rready_delay, data, resp);
    if (model_q[slot].size() > 0) expected = model_q[slot].pop_front();
    check("data register", expected, data);
    check("data register resp", 32'(axil_bus_pkg::AXIL_RESP_OKAY), 32'(resp));
  endtask

  task automatic read_status(input int slot, input logic [11:0] ofs, input int expected,
                             input string label);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(reg_addr(slot + `AXIL_FIRST_SLOT_IDX, ofs), 0, data, resp);
    check(label, expected, data);
    check({label, " resp"}, 32'(axil_bus_pkg::AXIL_RESP_OKAY), 32'(resp));
  endtask

  task automatic drain_slot(input int slot);
    while (model_q[slot].size() > 0) pop_and_compare(slot, 0);
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  task automatic read_rom();
    logic [31:0] data;
    logic [1:0]  resp;
    logic [31:0] expected [5];
    test_name   = "rom read";
    expected[0] = `AXIL_ROM_MAGIC;
    expected[1] = 32'(`AXIL_NUM_SLOTS);
    expected[2] = 32'(`AXIL_FIFO_DEPTH);
    expected[3] = `AXIL_ROM_VERSION;
    // word 5 is past the table
    expected[4] = 32'h0;
    for (int w = 0; w < 5; w++) begin
      axil_read(reg_addr(rom_idx_lp, 12'((w == 4 ? 5 : w) * 4)), 0, data, resp);
      check("rom word", expected[w], data);
      check("rom resp", 32'(axil_bus_pkg::AXIL_RESP_OKAY), 32'(resp));
    end
  endtask

  task automatic fifo_order();
    test_name = "fifo order";
    for (int s = 0; s < num_slots_lp; s++) begin
      for (int n = 0; n < 3; n++) push_word(s, $random(seed));
    end
    for (int s = 0; s < num_slots_lp; s++) begin
      drain_slot(s);
      // empty FIFO reads zero
      pop_and_compare(s, 0);
    end
  endtask

  task automatic status_regs();
    test_name = "status registers";
    for (int s = 0; s < num_slots_lp; s++) begin
      push_word(s, $random(seed));
      push_word(s, $random(seed));
      read_status(s, `AXIL_OFS_RDFO, model_q[s].size(), "occupancy");
      read_status(s, `AXIL_OFS_RLR, rx_total[s], "received count");
      pop_and_compare(s, 0);
      // one word gone while the total stays
      read_status(s, `AXIL_OFS_RDFO, model_q[s].size(), "occupancy after pop");
      read_status(s, `AXIL_OFS_RLR, rx_total[s], "received count after pop");
      drain_slot(s);
    end
  endtask

  task automatic decode_error();
    logic [31:0] data;
    logic [1:0]  resp;
    test_name = "decode error";
    // index 0 and the index past the ROM are unmapped
    axil_read(reg_addr(0, `AXIL_OFS_RDFO), 0, data, resp);
    check("slot 0 resp", 32'(axil_bus_pkg::AXIL_RESP_DECERR), 32'(resp));
    check("slot 0 data", 32'h0, data);
    axil_read(reg_addr(rom_idx_lp + 1, `AXIL_OFS_RDR), 0, data, resp);
    check("past rom resp", 32'(axil_bus_pkg::AXIL_RESP_DECERR), 32'(resp));
    check("past rom data", 32'h0, data);
    axil_read(reg_addr(rom_idx_lp, 12'h000), 0, data, resp);
    check("read after error", `AXIL_ROM_MAGIC, data);
    check("read after error resp", 32'(axil_bus_pkg::AXIL_RESP_OKAY), 32'(resp));
  endtask

  task automatic back_pressure();
    test_name = "back-pressure";
    push_word(0, $random(seed));
    push_word(0, $random(seed));
    pop_and_compare(0, 5);
    // exactly one word left the FIFO
    read_status(0, `AXIL_OFS_RDFO, model_q[0].size(), "occupancy");
    drain_slot(0);
  endtask

  task automatic full_fifo();
    int slot;
    slot      = num_slots_lp - 1;
    test_name = "full fifo";
    for (int n = 0; n < depth_lp; n++) push_word(slot, $random(seed));
    check("rx_ready when full", 32'd0, 32'(rx_ready[slot]));
    pop_and_compare(slot, 0);
    check("rx_ready after pop", 32'd1, 32'(rx_ready[slot]));
    read_status(slot, `AXIL_OFS_RDFO, model_q[slot].size(), "occupancy");
    drain_slot(slot);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    rx_v      = '0;
    rx_data   = '0;
    seed      = 46352;
    test_name = "reset";
    for (int s = 0; s < num_slots_lp; s++) rx_total[s] = 0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    check("arready after reset", 32'd1, 32'(arready));
    check("rvalid after reset", 32'd0, 32'(rvalid));
    check("rx_ready after reset", (1 << num_slots_lp) - 1, 32'(rx_ready));
    read_rom();
    fifo_order();
    status_regs();
    decode_error();
    back_pressure();
    full_fifo();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/axil_bus_pkg.sv
verilog/link_stream_pkg.sv
verilog/rx_stream_fifo.sv
verilog/rx_slot_status.sv
verilog/link_info_rom.sv
verilog/axil_rx_reader.sv
verilog/axil_rx_subsystem.sv
testbench/tb_axil_rx.sv

// ==== Makefile ====
# Verilator build for the AXI-Lite receive subsystem testbench
# any variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= tb_axil_rx
RTL_TOP    ?= axil_rx_subsystem
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --timescale 1ns/1ns -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ns

SOURCES := $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulator exits non-zero when the testbench stops with $fatal
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
